// File: rtl/aluUnit.sv
// Integer ALU for RV32I, result plus flags for the branch decision in the core
module aluUnit (
  input  cpuPkg::aluOpE            aluOp_i,
  input  logic [cpuPkg::BUS_W-1:0] a_i,
  input  logic [cpuPkg::BUS_W-1:0] b_i,
  output logic [cpuPkg::BUS_W-1:0] result_o,
  output logic                     zero_o,
  output logic                     negative_o,
  output logic                     overflow_o
);

  logic [4:0]               shamt;
  logic [cpuPkg::BUS_W-1:0] sum;
  logic [cpuPkg::BUS_W-1:0] diff;

  assign shamt = b_i[4:0];
  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;

  always_comb begin
    case (aluOp_i)
      cpuPkg::ALU_ADD:  result_o = sum;
      cpuPkg::ALU_SUB:  result_o = diff;
      cpuPkg::ALU_SLL:  result_o = a_i << shamt;
      cpuPkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      cpuPkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
      cpuPkg::ALU_XOR:  result_o = a_i ^ b_i;
      cpuPkg::ALU_SRL:  result_o = a_i >> shamt;
      cpuPkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      cpuPkg::ALU_OR:   result_o = a_i | b_i;
      cpuPkg::ALU_AND:  result_o = a_i & b_i;
      default:          result_o = '0;
    endcase
  end

  assign zero_o     = (result_o == '0);
  assign negative_o = result_o[cpuPkg::BUS_W-1];

  // Signed overflow, only meaningful for add and sub
  always_comb begin
    case (aluOp_i)
      cpuPkg::ALU_ADD: begin
        overflow_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
      end
      cpuPkg::ALU_SUB: begin
        overflow_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
      end
      default: begin
        overflow_o = 1'b0;
      end
    endcase
  end

endmodule

// File: rtl/controlUnit.sv
// Instruction decoder, turns the held instruction word into datapath and memory controls
module controlUnit (
  input  cpuPkg::instrU instr_i,
  output cpuPkg::aluOpE aluOp_o,
  output logic          aluSrc_o,
  output logic          auipc_o,
  output logic          lui_o,
  output logic          regWrite_o,
  output logic          memRead_o,
  output logic          memWrite_o,
  output cpuPkg::widthE width_o,
  output logic          unsigned_o,
  output logic [1:0]    jump_o,
  output logic [2:0]    branch_o
);

  logic [2:0] funct3;
  logic       altOp;
  logic       shiftRight;

  assign funct3     = instr_i.r.funct3;
  assign altOp      = instr_i.r.funct7[5];
  assign shiftRight = (funct3 == 3'b101);

  // Loads and stores share the funct3 width encoding
  always_comb begin
    case (funct3[1:0])
      2'b00:   width_o = cpuPkg::WIDTH_BYTE;
      2'b01:   width_o = cpuPkg::WIDTH_HALF;
      default: width_o = cpuPkg::WIDTH_WORD;
    endcase
  end

  assign unsigned_o = funct3[2];

  always_comb begin
    aluOp_o    = cpuPkg::ALU_ADD;
    aluSrc_o   = 1'b0;
    auipc_o    = 1'b0;
    lui_o      = 1'b0;
    regWrite_o = 1'b0;
    memRead_o  = 1'b0;
    memWrite_o = 1'b0;
    jump_o     = 2'b00;
    branch_o   = 3'b000;
    case (instr_i.r.opcode)
      cpuPkg::OPC_OP: begin
        regWrite_o = 1'b1;
        // Bit 30 only selects sub and sra
        aluOp_o = cpuPkg::aluOpE'({altOp & (shiftRight | (funct3 == 3'b000)), funct3});
      end
      cpuPkg::OPC_OPIMM: begin
        regWrite_o = 1'b1;
        aluSrc_o   = 1'b1;
        aluOp_o    = cpuPkg::aluOpE'({altOp & shiftRight, funct3});
      end
      cpuPkg::OPC_LOAD: begin
        regWrite_o = 1'b1;
        aluSrc_o   = 1'b1;
        memRead_o  = 1'b1;
      end
      cpuPkg::OPC_STORE: begin
        aluSrc_o   = 1'b1;
        memWrite_o = 1'b1;
      end
      cpuPkg::OPC_BRANCH: begin
        // One-hot compare kind: equality, signed less, unsigned less
        if (funct3[2:1] == 2'b11) begin
          aluOp_o  = cpuPkg::ALU_SLTU;
          branch_o = 3'b100;
        end else begin
          aluOp_o  = cpuPkg::ALU_SUB;
          branch_o = funct3[2] ? 3'b010 : 3'b001;
        end
      end
      cpuPkg::OPC_JAL: begin
        regWrite_o = 1'b1;
        jump_o     = 2'b01;
      end
      cpuPkg::OPC_JALR: begin
        regWrite_o = 1'b1;
        aluSrc_o   = 1'b1;
        jump_o     = 2'b10;
      end
      cpuPkg::OPC_LUI: begin
        regWrite_o = 1'b1;
        lui_o      = 1'b1;
      end
      cpuPkg::OPC_AUIPC: begin
        regWrite_o = 1'b1;
        aluSrc_o   = 1'b1;
        auipc_o    = 1'b1;
      end
      default: begin
        regWrite_o = 1'b0;
      end
    endcase
  end

endmodule

// File: rtl/cpuCore.sv
// Multicycle RV32I core top level, one shared bus for fetches, loads and stores
module cpuCore #(
  parameter logic [cpuPkg::BUS_W-1:0] RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     busy_i,
  input  logic [cpuPkg::BUS_W-1:0] busDat_i,
  output logic [cpuPkg::BUS_W-1:0] busDat_o,
  output logic [cpuPkg::BUS_W-1:0] busAdr_o,
  output logic [3:0]               busSel_o,
  output logic                     busWrite_o,
  output logic                     busRead_o
);

  localparam logic [1:0] PH_FETCH = 2'd0;
  localparam logic [1:0] PH_EXEC  = 2'd1;
  localparam logic [1:0] PH_MEM   = 2'd2;

  logic [1:0]               phase;
  logic                     coreRun;
  logic                     fetchSent;
  logic [cpuPkg::BUS_W-1:0] pc;
  cpuPkg::instrU            instrQ;

  cpuPkg::aluOpE            aluOp;
  cpuPkg::widthE            width;
  logic                     aluSrc, auipc, lui, regWrite, memRead, memWrite, isUnsigned;
  logic [1:0]               jump;
  logic [2:0]               branch;

  logic [cpuPkg::BUS_W-1:0] imm, rdata1, rdata2, aluA, aluB, aluResult;
  logic                     aluZero, aluNegative, aluOverflow;
  logic [cpuPkg::BUS_W-1:0] memRdata, pcPlus4, nextPc, wbData;
  logic                     instrReq, dataReq, ihit, dhit;
  logic                     memAccess, complete, branchCond, branchTaken;

  controlUnit uCtrl (
    .instr_i(instrQ), .aluOp_o(aluOp), .aluSrc_o(aluSrc), .auipc_o(auipc),
    .lui_o(lui), .regWrite_o(regWrite), .memRead_o(memRead), .memWrite_o(memWrite),
    .width_o(width), .unsigned_o(isUnsigned), .jump_o(jump), .branch_o(branch)
  );

  immediateGen uImm (.instr_i(instrQ), .imm_o(imm));

  assign aluA = auipc ? pc : rdata1;
  assign aluB = aluSrc ? imm : rdata2;

  aluUnit uAlu (
    .aluOp_i(aluOp), .a_i(aluA), .b_i(aluB), .result_o(aluResult),
    .zero_o(aluZero), .negative_o(aluNegative), .overflow_o(aluOverflow)
  );

  registerFile uRegs (
    .clk(clk), .rstN_i(rstN_i), .we_i(regWrite & complete),
    .rs1_i(instrQ.r.rs1), .rs2_i(instrQ.r.rs2), .rd_i(instrQ.r.rd),
    .wdata_i(wbData), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  requestUnit uReq (
    .clk(clk), .rstN_i(rstN_i), .instrReq_i(instrReq), .instrAdr_i(pc),
    .dataReq_i(dataReq), .dataWrite_i(memWrite), .dataAdr_i(aluResult),
    .dataWdata_i(rdata2), .width_i(width), .unsigned_i(isUnsigned),
    .ihit_o(ihit), .dhit_o(dhit), .rdata_o(memRdata),
    .busy_i(busy_i), .busDat_i(busDat_i), .busDat_o(busDat_o), .busAdr_o(busAdr_o),
    .busSel_o(busSel_o), .busWrite_o(busWrite_o), .busRead_o(busRead_o)
  );

  // One fetch strobe per FETCH phase, starting one edge after reset
  assign instrReq  = coreRun && (phase == PH_FETCH) && !fetchSent;
  assign memAccess = memRead | memWrite;
  assign dataReq   = (phase == PH_EXEC) && memAccess;
  assign complete  = ((phase == PH_EXEC) && !memAccess) || ((phase == PH_MEM) && dhit);

  // Signed less from N xor V, unsigned less from the sltu result
  always_comb begin
    if (branch[0]) begin
      branchCond = aluZero;
    end else if (branch[1]) begin
      branchCond = aluNegative ^ aluOverflow;
    end else begin
      branchCond = !aluZero;
    end
  end

  // funct3[0] inverts the sense: bne, bge, bgeu
  assign branchTaken = (|branch) && (branchCond ^ instrQ.b.funct3[0]);
  assign pcPlus4     = pc + 32'd4;

  always_comb begin
    if (jump[1]) begin
      nextPc = {aluResult[cpuPkg::BUS_W-1:1], 1'b0};
    end else if (jump[0] || branchTaken) begin
      nextPc = pc + imm;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_comb begin
    if (|jump) begin
      wbData = pcPlus4;
    end else if (memRead) begin
      wbData = memRdata;
    end else if (lui) begin
      wbData = imm;
    end else begin
      wbData = aluResult;
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      phase     <= PH_FETCH;
      pc        <= RESET_PC;
      fetchSent <= 1'b0;
      coreRun   <= 1'b0;
    end else begin
      coreRun <= 1'b1;
      case (phase)
        PH_FETCH: begin
          if (ihit) begin
            fetchSent <= 1'b0;
            phase     <= PH_EXEC;
          end else if (instrReq) begin
            fetchSent <= 1'b1;
          end
        end
        PH_EXEC: phase <= memAccess ? PH_MEM : PH_FETCH;
        PH_MEM: begin
          if (dhit) begin
            phase <= PH_FETCH;
          end
        end
        default: phase <= PH_FETCH;
      endcase
      if (complete) begin
        pc <= nextPc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ihit) begin
      instrQ <= memRdata;
    end
  end

endmodule

// File: rtl/cpuPkg.sv
// Shared RV32I encodings and instruction layouts, referenced by scoped name from the core RTL
package cpuPkg;

  // Address and data width of the core and the bus
  localparam int BUS_W = 32;

  // Major opcodes in bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OPIMM  = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcodeE;

  // Encoded as {funct7[5], funct3} so register ops map straight across
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } aluOpE;

  // Same values as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'b00,
    WIDTH_HALF = 2'b01,
    WIDTH_WORD = 2'b10
  } widthE;

  // One instruction word seen through each RV32I format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcodeE     opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcodeE      opcode;
    } i;
    struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      opcodeE     opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      opcodeE     opcode;
    } b;
    struct packed {
      logic [19:0] imm31to12;
      logic [4:0]  rd;
      opcodeE      opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      opcodeE     opcode;
    } j;
  } instrU;

endpackage

// File: rtl/immediateGen.sv
// Immediate generator, builds the sign-extended immediate of the held instruction
module immediateGen (
  input  cpuPkg::instrU            instr_i,
  output logic [cpuPkg::BUS_W-1:0] imm_o
);

  always_comb begin
    case (instr_i.r.opcode)
      cpuPkg::OPC_OPIMM, cpuPkg::OPC_LOAD, cpuPkg::OPC_JALR: begin
        imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
      end
      cpuPkg::OPC_STORE: begin
        imm_o = {{20{instr_i.s.immHi[6]}}, instr_i.s.immHi, instr_i.s.immLo};
      end
      cpuPkg::OPC_BRANCH: begin
        // Branch offsets are in halfwords
        imm_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                 instr_i.b.imm10to5, instr_i.b.imm4to1, 1'b0};
      end
      cpuPkg::OPC_LUI, cpuPkg::OPC_AUIPC: begin
        imm_o = {instr_i.u.imm31to12, 12'b0};
      end
      cpuPkg::OPC_JAL: begin
        imm_o = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19to12,
                 instr_i.j.imm11, instr_i.j.imm10to1, 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

// File: rtl/registerFile.sv
// Integer register file with two asynchronous reads, one clocked write and x0 fixed at zero
module registerFile (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     we_i,
  input  logic [4:0]               rs1_i,
  input  logic [4:0]               rs2_i,
  input  logic [4:0]               rd_i,
  input  logic [cpuPkg::BUS_W-1:0] wdata_i,
  output logic [cpuPkg::BUS_W-1:0] rdata1_o,
  output logic [cpuPkg::BUS_W-1:0] rdata2_o
);

  logic [cpuPkg::BUS_W-1:0] regs [32];

  // x0 keeps its reset value because writes to it are dropped
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int idx = 0; idx < 32; idx++) begin
        regs[idx] <= '0;
      end
    end else if (we_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

// File: rtl/requestUnit.sv
// Bus request unit, puts one fetch or data access at a time on the bus and signals its completion
module requestUnit (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     instrReq_i,
  input  logic [cpuPkg::BUS_W-1:0] instrAdr_i,
  input  logic                     dataReq_i,
  input  logic                     dataWrite_i,
  input  logic [cpuPkg::BUS_W-1:0] dataAdr_i,
  input  logic [cpuPkg::BUS_W-1:0] dataWdata_i,
  input  cpuPkg::widthE            width_i,
  input  logic                     unsigned_i,
  output logic                     ihit_o,
  output logic                     dhit_o,
  output logic [cpuPkg::BUS_W-1:0] rdata_o,
  input  logic                     busy_i,
  input  logic [cpuPkg::BUS_W-1:0] busDat_i,
  output logic [cpuPkg::BUS_W-1:0] busDat_o,
  output logic [cpuPkg::BUS_W-1:0] busAdr_o,
  output logic [3:0]               busSel_o,
  output logic                     busWrite_o,
  output logic                     busRead_o
);

  logic                     start;
  logic                     done;
  logic                     pendQ;
  logic                     sawBusyQ;
  logic                     isDataQ;
  logic                     unsignedQ;
  logic [1:0]               laneQ;
  cpuPkg::widthE            reqWidth;
  cpuPkg::widthE            widthQ;
  logic [cpuPkg::BUS_W-1:0] reqAdr;
  logic [cpuPkg::BUS_W-1:0] reqDat;
  logic [3:0]               reqSel;
  logic [cpuPkg::BUS_W-1:0] adrQ;
  logic [cpuPkg::BUS_W-1:0] datQ;
  logic [3:0]               selQ;
  logic [4:0]               shiftAmt;
  logic [cpuPkg::BUS_W-1:0] shifted;

  // Strobes go out in the same cycle as the request
  assign start      = instrReq_i | dataReq_i;
  assign busRead_o  = instrReq_i | (dataReq_i & ~dataWrite_i);
  assign busWrite_o = ~instrReq_i & dataReq_i & dataWrite_i;

  assign reqAdr   = instrReq_i ? instrAdr_i : dataAdr_i;
  assign reqWidth = instrReq_i ? cpuPkg::WIDTH_WORD : width_i;

  // Lane select and replicated write data
  always_comb begin
    case (reqWidth)
      cpuPkg::WIDTH_BYTE: begin
        reqSel = 4'b0001 << reqAdr[1:0];
        reqDat = {4{dataWdata_i[7:0]}};
      end
      cpuPkg::WIDTH_HALF: begin
        reqSel = reqAdr[1] ? 4'b1100 : 4'b0011;
        reqDat = {2{dataWdata_i[15:0]}};
      end
      default: begin
        reqSel = 4'b1111;
        reqDat = dataWdata_i;
      end
    endcase
  end

  // Held copies keep the bus stable until busy falls
  assign busAdr_o = start ? {reqAdr[cpuPkg::BUS_W-1:2], 2'b00} : adrQ;
  assign busSel_o = start ? reqSel : selQ;
  assign busDat_o = start ? reqDat : datQ;

  always_ff @(posedge clk) begin
    if (start) begin
      adrQ      <= {reqAdr[cpuPkg::BUS_W-1:2], 2'b00};
      selQ      <= reqSel;
      datQ      <= reqDat;
      laneQ     <= reqAdr[1:0];
      widthQ    <= reqWidth;
      unsignedQ <= unsigned_i;
      isDataQ   <= ~instrReq_i;
    end
  end

  // Completion is the first low busy after it has been high
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      pendQ    <= 1'b0;
      sawBusyQ <= 1'b0;
    end else if (start) begin
      pendQ    <= 1'b1;
      sawBusyQ <= 1'b0;
    end else if (done) begin
      pendQ    <= 1'b0;
      sawBusyQ <= 1'b0;
    end else if (pendQ && busy_i) begin
      sawBusyQ <= 1'b1;
    end
  end

  assign done   = pendQ & sawBusyQ & ~busy_i;
  assign ihit_o = done & ~isDataQ;
  assign dhit_o = done & isDataQ;

  // Move the addressed lane down, then extend
  always_comb begin
    case (widthQ)
      cpuPkg::WIDTH_BYTE: shiftAmt = {laneQ, 3'b000};
      cpuPkg::WIDTH_HALF: shiftAmt = {laneQ[1], 4'b0000};
      default:            shiftAmt = 5'd0;
    endcase
  end

  assign shifted = busDat_i >> shiftAmt;

  always_comb begin
    case (widthQ)
      cpuPkg::WIDTH_BYTE: rdata_o = {{24{~unsignedQ & shifted[7]}}, shifted[7:0]};
      cpuPkg::WIDTH_HALF: rdata_o = {{16{~unsignedQ & shifted[15]}}, shifted[15:0]};
      default:            rdata_o = busDat_i;
    endcase
  end

endmodule

// File: src.f
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/immediateGen.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/requestUnit.sv
rtl/cpuCore.sv
verif/busMemory.sv
verif/cpuTb.sv

// File: verif/busMemory.sv
// Behavioral bus memory for the core testbench, random busy latency, program written in by the testbench
module busMemory #(
  parameter int          WORDS = 256,
  parameter logic [31:0] SEED  = 32'h1
) (
  input  logic        clk,
  input  logic        rstN_i,
  input  logic        busRead_i,
  input  logic        busWrite_i,
  input  logic [31:0] busAdr_i,
  input  logic [3:0]  busSel_i,
  input  logic [31:0] busDat_i,
  output logic        busy_o,
  output logic [31:0] busDat_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  logic [31:0] rng;
  logic [31:0] nxt;
  logic [31:0] rdWord;
  logic [2:0]  left;
  logic [AW-1:0] idx;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fill pattern follows the full byte address
  initial begin
    for (int k = 0; k < WORDS; k++) begin
      mem[k] = 32'hA5A5_0000 ^ (32'(k) << 2);
    end
    busy_o   = 1'b0;
    busDat_o = '0;
  end

  assign idx = busAdr_i[AW+1:2];

  always @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      busy_o <= 1'b0;
      left   <= '0;
      rng    <= SEED;
    end else if (left != 3'd0) begin
      left <= left - 3'd1;
      // Last busy cycle, read data shows up as busy drops
      if (left == 3'd1) begin
        busy_o   <= #1 1'b0;
        busDat_o <= #1 rdWord;
      end
    end else if (busRead_i || busWrite_i) begin
      nxt = xorshift(rng);
      rng    <= nxt;
      left   <= 3'(nxt[1:0]) + 3'd1;
      busy_o <= #1 1'b1;
      rdWord <= mem[idx];
      if (busWrite_i) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (busSel_i[lane]) begin
            mem[idx][8*lane +: 8] = busDat_i[8*lane +: 8];
          end
        end
      end
    end
  end

endmodule

// File: verif/cpuTb.sv
// Testbench for the multicycle core that runs a hand-assembled program and checks its bus traffic by assertions
module cpuTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] RESET_PC = 32'h0000_0100;
  localparam int T_FETCH = 0;
  localparam int T_BUS   = 1;
  localparam int T_ALU   = 2;
  localparam int T_MEM   = 3;
  localparam int T_FLOW  = 4;
  localparam int T_ZERO  = 5;

  logic        clk = 1'b0;
  logic        rstN = 1'b0;
  logic        busy_i;
  logic [31:0] busDat_i;
  logic [31:0] busDat_o;
  logic [31:0] busAdr_o;
  logic [3:0]  busSel_o;
  logic        busWrite_o;
  logic        busRead_o;

  // Program image and expected store table
  logic [31:0] image [256];
  logic [31:0] expAdr [64];
  logic [3:0]  expSel [64];
  logic [31:0] expDat [64];
  int          expGroup [64];
  int          groupEnd [6];
  int          errCount [6];
  string       testName [6] = '{"fetch", "busRule", "aluImm", "loadStore", "control", "regZero"};
  int          nExp = 0;
  int          nInstr = 0;
  int          watchLimit = 0;
  logic [31:0] buildPc;
  logic [11:0] resOff;

  // Bus monitor state
  int          wrIdx;
  logic        inFlight;
  logic        sawBusy;
  logic [31:0] holdAdr;
  logic [3:0]  holdSel;
  logic [31:0] holdDat;
  logic        seenFetch;
  logic        prevCtrl;
  logic [31:0] prevFetch;

  always #2 clk = ~clk;

  cpuCore #(.RESET_PC(RESET_PC)) u_dut (
    .clk(clk), .rstN_i(rstN), .busy_i(busy_i), .busDat_i(busDat_i), .busDat_o(busDat_o),
    .busAdr_o(busAdr_o), .busSel_o(busSel_o), .busWrite_o(busWrite_o), .busRead_o(busRead_o)
  );

  busMemory #(.WORDS(256), .SEED(32'h8dfe55b5)) u_mem (
    .clk(clk), .rstN_i(rstN), .busRead_i(busRead_o), .busWrite_i(busWrite_o),
    .busAdr_i(busAdr_o), .busSel_i(busSel_o), .busDat_i(busDat_o),
    .busy_o(busy_i), .busDat_o(busDat_i)
  );

  // Instruction encoders for the RV32I formats
  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, cpuPkg::OPC_OP};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], cpuPkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpuPkg::OPC_JAL};
  endfunction

  function automatic logic branchRule(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic isControl(input logic [31:0] word);
    return (word[6:0] == cpuPkg::OPC_BRANCH) || (word[6:0] == cpuPkg::OPC_JAL) ||
           (word[6:0] == cpuPkg::OPC_JALR);
  endfunction

  task automatic emit(input logic [31:0] word);
    image[buildPc[9:2]] = word;
    u_mem.mem[buildPc[9:2]] = word;
    buildPc = buildPc + 32'd4;
    nInstr++;
  endtask

  task automatic expectStore(input int grp, input logic [31:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat);
    expAdr[nExp]   = adr;
    expSel[nExp]   = sel;
    expDat[nExp]   = dat;
    expGroup[nExp] = grp;
    groupEnd[grp]  = nExp;
    nExp++;
  endtask

  // Word store of a register into the next slot of the result area
  task automatic storeResult(input int grp, input logic [4:0] rs, input logic [31:0] value);
    emit(encS(resOff, rs, 5'd10, 3'b010));
    expectStore(grp, 32'h200 + {20'b0, resOff}, 4'hF, value);
    resOff = resOff + 12'd4;
  endtask

  task automatic aluCase(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] value);
    emit(encR(f7, 5'd2, 5'd1, f3, 5'd4));
    storeResult(T_ALU, 5'd4, value);
  endtask

  task automatic loadCase(input logic [2:0] f3, input logic [11:0] off,
                          input logic [31:0] value);
    emit(encI(off, 5'd11, f3, 5'd5, cpuPkg::OPC_LOAD));
    storeResult(T_MEM, 5'd5, value);
  endtask

  // Forward branch over one store that lands in the table only when not taken
  task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [31:0] v1,
                            input logic [4:0] rs2, input logic [31:0] v2);
    emit(encB(13'd8, rs2, rs1, f3));
    if (branchRule(f3, v1, v2)) begin
      emit(encS(12'h2F0, 5'd12, 5'd0, 3'b010));
    end else begin
      storeResult(T_FLOW, 5'd12, 32'h77);
    end
  endtask

  task automatic buildProgram();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] scratch;
    logic [31:0] pcMark;
    a = 32'hFFFF_FFF9;
    b = 32'd5;
    c = 32'hFFFF_FFFE;
    buildPc = RESET_PC;
    resOff = 12'd0;
    emit(encI(12'h200, 5'd0, 3'b000, 5'd10, cpuPkg::OPC_OPIMM));
    emit(encI(12'h280, 5'd0, 3'b000, 5'd11, cpuPkg::OPC_OPIMM));
    emit(encI(12'hFF9, 5'd0, 3'b000, 5'd1, cpuPkg::OPC_OPIMM));
    emit(encI(12'h005, 5'd0, 3'b000, 5'd2, cpuPkg::OPC_OPIMM));
    emit(encI(12'hFFE, 5'd0, 3'b000, 5'd6, cpuPkg::OPC_OPIMM));
    emit(encI(12'h077, 5'd0, 3'b000, 5'd12, cpuPkg::OPC_OPIMM));
    // Register-register ops on x1 = -7 and x2 = 5, results worked out by hand
    aluCase(7'h00, 3'b000, 32'hFFFF_FFFE);
    aluCase(7'h20, 3'b000, 32'hFFFF_FFF4);
    aluCase(7'h00, 3'b001, 32'hFFFF_FF20);
    aluCase(7'h00, 3'b010, 32'h0000_0001);
    aluCase(7'h00, 3'b011, 32'h0000_0000);
    aluCase(7'h00, 3'b100, 32'hFFFF_FFFC);
    aluCase(7'h00, 3'b101, 32'h07FF_FFFF);
    aluCase(7'h20, 3'b101, 32'hFFFF_FFFF);
    aluCase(7'h00, 3'b110, 32'hFFFF_FFFD);
    aluCase(7'h00, 3'b111, 32'h0000_0001);
    emit(encI(12'h555, 5'd1, 3'b100, 5'd4, cpuPkg::OPC_OPIMM));
    storeResult(T_ALU, 5'd4, a ^ 32'h555);
    emit(encI({7'h20, 5'd1}, 5'd1, 3'b101, 5'd4, cpuPkg::OPC_OPIMM));
    storeResult(T_ALU, 5'd4, 32'hFFFF_FFFC);
    emit(encU(20'hABCDE, 5'd4, cpuPkg::OPC_LUI));
    storeResult(T_ALU, 5'd4, 32'hABCD_E000);
    pcMark = buildPc;
    emit(encU(20'h00001, 5'd4, cpuPkg::OPC_AUIPC));
    storeResult(T_ALU, 5'd4, pcMark + 32'h1000);
    // Build a scratch word from a word, a byte and a half store
    emit(encS(12'd0, 5'd2, 5'd11, 3'b010));
    expectStore(T_MEM, 32'h280, 4'b1111, b);
    emit(encS(12'd1, 5'd1, 5'd11, 3'b000));
    expectStore(T_MEM, 32'h280, 4'b0010, {4{a[7:0]}});
    emit(encS(12'd2, 5'd6, 5'd11, 3'b001));
    expectStore(T_MEM, 32'h280, 4'b1100, {2{c[15:0]}});
    scratch = {c[15:0], a[7:0], b[7:0]};
    loadCase(3'b000, 12'd1, {{24{scratch[15]}}, scratch[15:8]});
    loadCase(3'b100, 12'd1, {24'b0, scratch[15:8]});
    loadCase(3'b001, 12'd2, {{16{scratch[31]}}, scratch[31:16]});
    loadCase(3'b101, 12'd2, {16'b0, scratch[31:16]});
    loadCase(3'b010, 12'd0, scratch);
    // Rest of the program lives above the result area
    emit(encJ(21'(32'h300 - buildPc), 5'd0));
    buildPc = 32'h300;
    branchCase(3'b000, 5'd2, b, 5'd2, b);
    branchCase(3'b000, 5'd1, a, 5'd2, b);
    branchCase(3'b001, 5'd1, a, 5'd2, b);
    branchCase(3'b001, 5'd2, b, 5'd2, b);
    branchCase(3'b100, 5'd1, a, 5'd2, b);
    branchCase(3'b100, 5'd2, b, 5'd1, a);
    branchCase(3'b101, 5'd2, b, 5'd1, a);
    branchCase(3'b101, 5'd1, a, 5'd2, b);
    branchCase(3'b110, 5'd2, b, 5'd1, a);
    branchCase(3'b110, 5'd1, a, 5'd2, b);
    branchCase(3'b111, 5'd1, a, 5'd2, b);
    branchCase(3'b111, 5'd2, b, 5'd1, a);
    pcMark = buildPc;
    emit(encJ(21'd8, 5'd7));
    emit(encS(12'h2F0, 5'd12, 5'd0, 3'b010));
    storeResult(T_FLOW, 5'd7, pcMark + 32'd4);
    // Odd JALR offset drops bit 0 of the target
    pcMark = buildPc;
    emit(encU(20'h0, 5'd8, cpuPkg::OPC_AUIPC));
    emit(encI(12'd13, 5'd8, 3'b000, 5'd9, cpuPkg::OPC_JALR));
    emit(encS(12'h2F0, 5'd12, 5'd0, 3'b010));
    storeResult(T_FLOW, 5'd9, pcMark + 32'd8);
    emit(encI(12'h123, 5'd0, 3'b000, 5'd0, cpuPkg::OPC_OPIMM));
    storeResult(T_ZERO, 5'd0, 32'h0);
    emit(encJ(21'd0, 5'd0));
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      wrIdx     <= 0;
      inFlight  <= 1'b0;
      sawBusy   <= 1'b0;
      seenFetch <= 1'b0;
      prevCtrl  <= 1'b0;
    end else begin
      if (busWrite_o) begin
        wrIdx <= wrIdx + 1;
      end
      if (busRead_o || busWrite_o) begin
        inFlight <= 1'b1;
        sawBusy  <= 1'b0;
        holdAdr  <= busAdr_o;
        holdSel  <= busSel_o;
        holdDat  <= busDat_o;
      end else if (inFlight && busy_i) begin
        sawBusy <= 1'b1;
      end else if (inFlight && sawBusy) begin
        inFlight <= 1'b0;
      end
      if (u_dut.instrReq) begin
        seenFetch <= 1'b1;
        prevFetch <= busAdr_o;
        prevCtrl  <= isControl(image[busAdr_o[9:2]]);
      end
    end
  end

  firstFetch: assert property (@(posedge clk) $rose(rstN) |=>
      u_dut.instrReq && busRead_o && busAdr_o == RESET_PC)
    else begin
      errCount[T_FETCH]++;
      $display("[ERROR] first fetch busAdr_o=%h expected %h", $sampled(busAdr_o), RESET_PC);
    end

  fetchShape: assert property (@(posedge clk) disable iff (!rstN)
      u_dut.instrReq |-> busRead_o && busAdr_o[1:0] == 2'b00 && busSel_o == 4'hF)
    else begin
      errCount[T_FETCH]++;
      $display("[ERROR] fetch busAdr_o=%h busSel_o=%h", $sampled(busAdr_o),
               $sampled(busSel_o));
    end

  fetchStep: assert property (@(posedge clk) disable iff (!rstN)
      u_dut.instrReq && seenFetch && !prevCtrl |-> busAdr_o == prevFetch + 32'd4)
    else begin
      errCount[T_FETCH]++;
      $display("[ERROR] sequential fetch busAdr_o=%h expected %h", $sampled(busAdr_o),
               $sampled(prevFetch) + 32'd4);
    end

  strobeIdle: assert property (@(posedge clk) disable iff (!rstN)
      busRead_o || busWrite_o |-> !busy_i)
    else begin
      errCount[T_BUS]++;
      $display("Bus strobe issued while busy_i was high");
    end

  busHold: assert property (@(posedge clk) disable iff (!rstN)
      inFlight |-> busAdr_o == holdAdr && busSel_o == holdSel && busDat_o == holdDat)
    else begin
      errCount[T_BUS]++;
      $display("[ERROR] held bus busAdr_o=%h/%h busSel_o=%h/%h busDat_o=%h/%h",
               $sampled(busAdr_o), $sampled(holdAdr), $sampled(busSel_o),
               $sampled(holdSel), $sampled(busDat_o), $sampled(holdDat));
    end

  storeExtra: assert property (@(posedge clk) disable iff (!rstN)
      busWrite_o |-> wrIdx < nExp)
    else begin
      errCount[T_FLOW]++;
      $display("Store to %h appeared after all expected stores", $sampled(busAdr_o));
    end

  storeData: assert property (@(posedge clk) disable iff (!rstN)
      busWrite_o && wrIdx < nExp |-> busAdr_o == expAdr[wrIdx] &&
      busSel_o == expSel[wrIdx] && busDat_o == expDat[wrIdx])
    else begin
      errCount[expGroup[$sampled(wrIdx)]]++;
      $display("[ERROR] store %0d busAdr_o=%h exp %h busSel_o=%h exp %h busDat_o=%h exp %h",
               $sampled(wrIdx), $sampled(busAdr_o), expAdr[$sampled(wrIdx)],
               $sampled(busSel_o), expSel[$sampled(wrIdx)], $sampled(busDat_o),
               expDat[$sampled(wrIdx)]);
    end

  task automatic reportTest(input int grp);
    $display("%s: %s, %0d errors", testName[grp], (errCount[grp] == 0) ? "ok" : "FAIL",
             errCount[grp]);
  endtask

  // Upper bound of 12 cycles per instruction plus slack
  initial begin
    wait (watchLimit > 0);
    repeat (watchLimit) @(posedge clk);
    $display("Timeout after %0d cycles, the program did not complete its stores", watchLimit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int failed;
    int total;
    failed = 0;
    total = 0;
    for (int g = 0; g < 6; g++) begin
      errCount[g] = 0;
      groupEnd[g] = 0;
    end
    @(posedge clk);
    buildProgram();
    watchLimit = nInstr * 12 + 200;
    repeat (3) @(posedge clk);
    #1 rstN = 1'b1;
    for (int g = T_ALU; g <= T_ZERO; g++) begin
      wait (wrIdx > groupEnd[g]);
      @(posedge clk);
      reportTest(g);
    end
    repeat (8) @(posedge clk);
    reportTest(T_FETCH);
    reportTest(T_BUS);
    for (int g = 0; g < 6; g++) begin
      total += errCount[g];
      if (errCount[g] != 0) begin
        failed++;
      end
    end
    $display("Summary: 6 tests, %0d failed, %0d errors, %0d stores", failed, total, wrIdx);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
